// File: bus_access.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

// latches what the chip reads off the data bus
// c-access char pointer, g-access bitmap
// p-access sprite pointer, s-access sprite bitmap
module bus_access
    import vic_pkg::*;
(
    input  logic            rst,
    input  logic            clk_dot4x,
    input  logic            phi_phase_start_dav,
    input  cycle_type_t     cycle_type,
    input  bus_word_t       dbi,
    input  logic            idle,
    input  sprite_idx_t     sprite_cnt,
    input  logic            aec,
    input  sprite_mask_t    sprite_dma,
    output sprite_ptr_bus_t sprite_ptr_o,
    output pixel_byte_t     pixels_read,
    output sprite_pix_bus_t sprite_pixels_o,
    output char_word_t      char_read,
    output char_word_t      char_next
);

    pixel_byte_t sprite_ptr [`NUM_SPRITES];
    logic [23:0] sprite_pixels [`NUM_SPRITES];

    // one row of char pointers, refilled each badline
    char_word_t char_buf [`CHARS_PER_LINE];
    logic [$clog2(`CHARS_PER_LINE)-1:0] char_idx;
    char_word_t char_fetch;

    logic c_badline;
    logic c_slot;
    logic g_paired;
    logic g_slot;
    logic s_slot;

    // cycle decode
    assign c_badline = (cycle_type == `VIC_HRC) || (cycle_type == `VIC_HGC);
    assign c_slot = c_badline || (cycle_type == `VIC_HRX) || (cycle_type == `VIC_HGI);
    assign g_paired = (cycle_type == `VIC_HGC) || (cycle_type == `VIC_HGI);
    assign g_slot = g_paired || (cycle_type == `VIC_LG);
    assign s_slot = (cycle_type == `VIC_HS1) || (cycle_type == `VIC_LS2) ||
                    (cycle_type == `VIC_HS3);

    // sprite 0 ends up in the top bits
    always_comb begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            sprite_ptr_o[(`NUM_SPRITES-1-n)*8 +: 8] = sprite_ptr[n];
            sprite_pixels_o[(`NUM_SPRITES-1-n)*24 +: 24] = sprite_pixels[n];
        end
    end

    // badline reads colour always, byte only when the vic owns the bus
    always_comb begin
        if (c_badline) begin
            char_fetch = {dbi[11:8], aec ? 8'hff : dbi[7:0]};
        end else begin
            // replay from the line buffer
            char_fetch = char_buf[char_idx];
        end
    end

    // c-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            char_idx <= '0;
            char_next <= '0;
        end else if (phi_phase_start_dav && c_slot) begin
            char_next <= char_fetch;
            if (char_idx == `CHARS_PER_LINE - 1) begin
                char_idx <= '0;
            end else begin
                char_idx <= char_idx + 1'b1;
            end
        end
    end

    // buffer only written on badlines
    always_ff @(posedge clk_dot4x) begin
        if (phi_phase_start_dav && c_badline) begin
            char_buf[char_idx] <= char_fetch;
        end
    end

    // g-access, char half comes first on a paired strobe
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_read <= '0;
            char_read <= '0;
        end else if (phi_phase_start_dav) begin
            pixels_read <= '0;
            if (g_slot) begin
                pixels_read <= dbi[7:0];
                if (idle) begin
                    char_read <= '0;
                end else if (g_paired) begin
                    char_read <= char_fetch;
                end else begin
                    char_read <= char_next;
                end
            end
        end
    end

    // p-access, 0xff marks a sprite without dma
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                sprite_ptr[n] <= '0;
            end
        end else if (phi_phase_start_dav && (cycle_type == `VIC_LP)) begin
            if (sprite_dma[sprite_cnt]) begin
                sprite_ptr[sprite_cnt] <= dbi[7:0];
            end else begin
                sprite_ptr[sprite_cnt] <= 8'hff;
            end
        end
    end

    // s-access, shift a byte in from the bottom
    always_ff @(posedge clk_dot4x) begin
        if (phi_phase_start_dav && s_slot && sprite_dma[sprite_cnt]) begin
            sprite_pixels[sprite_cnt] <= {sprite_pixels[sprite_cnt][15:0], dbi[7:0]};
        end
    end

endmodule

// File: tb_vic_fetch.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module tb_vic_fetch
    import vic_pkg::*;
();

    // longest gap between two checkpoints is well under 64 lines
    localparam int WAIT_TICKS = 64 * `CYCLES_PER_LINE * `PHASE_TICKS;
    localparam int APB_WAIT_TICKS = 16;

    logic clk_dot4x;
    logic rst;
    logic [3:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] pwdata;
    bus_word_t dbi;
    logic [7:0] prdata;
    logic pready;
    raster_t raster_line;
    cycle_num_t raster_cycle;
    logic phi_phase_start_dav;
    pixel_byte_t pixels_read;
    char_word_t char_read;
    sprite_ptr_bus_t sprite_ptr_o;
    sprite_pix_bus_t sprite_pixels_o;

    // bus model state, one xorshift step per strobe
    logic [31:0] seed;
    logic [31:0] bus_state;
    int strobe_count;
    int error_count;
    int check_count;
    // ticks since the last strobe began
    int gap_ticks;

    vic_fetch_top vic_fetch_top_inst (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .dbi(dbi),
        .prdata(prdata),
        .pready(pready),
        .raster_line(raster_line),
        .raster_cycle(raster_cycle),
        .phi_phase_start_dav(phi_phase_start_dav),
        .pixels_read(pixels_read),
        .char_read(char_read),
        .sprite_ptr_o(sprite_ptr_o),
        .sprite_pixels_o(sprite_pixels_o)
    );

    // 4 ns period
    always #2 clk_dot4x = ~clk_dot4x;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word on the bus during strobe number idx
    function automatic bus_word_t bus_word_at(input int idx);
        logic [31:0] st;
        st = seed;
        for (int i = 0; i <= idx; i++) begin
            st = xorshift(st);
        end
        return st[11:0];
    endfunction

    // bus steps on the edge that ends each strobe tick
    always @(posedge clk_dot4x) begin : drive_bus
        logic [31:0] nxt;
        if (rst) begin
            nxt = xorshift(seed);
            bus_state <= nxt;
            dbi <= nxt[11:0];
            strobe_count <= 0;
        end else if (phi_phase_start_dav) begin
            nxt = xorshift(bus_state);
            bus_state <= nxt;
            dbi <= nxt[11:0];
            strobe_count <= strobe_count + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string what);
        error_count++;
        abort_run($sformatf("[ERROR] %0t ns: %s", $time, what));
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [7:0] got,
                             input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            report_mismatch($sformatf("register %0d read %02h, expected %02h", addr, got, exp));
        end
    endtask

    task automatic check_position(input raster_t got_line, input cycle_num_t got_cycle,
                                  input raster_t exp_line, input cycle_num_t exp_cycle);
        check_count++;
        if ((got_line !== exp_line) || (got_cycle !== exp_cycle)) begin
            report_mismatch($sformatf("raster at line %0d cycle %0d, expected %0d cycle %0d",
                                      got_line, got_cycle, exp_line, exp_cycle));
        end
    endtask

    task automatic check_strobe_gap(input int got, input int exp);
        check_count++;
        if (got != exp) begin
            report_mismatch($sformatf("strobe came %0d ticks after the last, expected %0d",
                                      got, exp));
        end
    endtask

    task automatic check_pixel(input pixel_byte_t got, input pixel_byte_t exp);
        check_count++;
        if (got !== exp) begin
            report_mismatch($sformatf("pixels_read %02h, expected %02h", got, exp));
        end
    endtask

    task automatic check_char(input char_word_t got, input char_word_t exp);
        check_count++;
        if (got !== exp) begin
            report_mismatch($sformatf("char_read %03h, expected %03h", got, exp));
        end
    endtask

    // sprite 0 sits in the top byte
    task automatic check_ptr(input sprite_ptr_bus_t bus, input sprite_idx_t n,
                             input pixel_byte_t exp);
        pixel_byte_t got;
        got = bus[(`NUM_SPRITES - 1 - n) * 8 +: 8];
        check_count++;
        if (got !== exp) begin
            report_mismatch($sformatf("sprite %0d pointer %02h, expected %02h", n, got, exp));
        end
    endtask

    task automatic check_sprite(input sprite_pix_bus_t bus, input sprite_idx_t n,
                                input logic [23:0] exp);
        logic [23:0] got;
        got = bus[(`NUM_SPRITES - 1 - n) * 24 +: 24];
        check_count++;
        if (got !== exp) begin
            report_mismatch($sformatf("sprite %0d data %06h, expected %06h", n, got, exp));
        end
    endtask

    // strobe every PHASE_TICKS ticks, the first one counted from the fall of rst
    always @(negedge clk_dot4x) begin
        if (rst) begin
            gap_ticks <= 0;
        end else if (phi_phase_start_dav) begin
            check_strobe_gap(gap_ticks, `PHASE_TICKS);
            gap_ticks <= 1;
        end else begin
            gap_ticks <= gap_ticks + 1;
        end
    end

    task automatic reset_dut();
        rst <= 1'b1;
        repeat (4) @(posedge clk_dot4x);
        rst <= 1'b0;
    endtask

    // setup then access, pready sampled mid-tick
    task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [7:0] data,
                                output logic [7:0] rdata);
        int ticks;
        @(posedge clk_dot4x);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk_dot4x);
        penable <= 1'b1;
        ticks = 0;
        @(negedge clk_dot4x);
        while (!pready) begin
            ticks++;
            if (ticks > APB_WAIT_TICKS) begin
                abort_run("timed out waiting for pready on the APB bus");
            end
            @(negedge clk_dot4x);
        end
        rdata = prdata;
        @(posedge clk_dot4x);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    // returns in the middle of strobe tick idx
    task automatic wait_for_strobe(input int idx);
        int ticks;
        ticks = 0;
        @(negedge clk_dot4x);
        while (!(phi_phase_start_dav && (strobe_count == idx))) begin
            ticks++;
            if (ticks > WAIT_TICKS) begin
                abort_run($sformatf("timed out waiting for bus cycle number %0d", idx));
            end
            @(negedge clk_dot4x);
        end
    endtask

    task automatic run_checkpoint(input int line, input int cyc, input int kind, input int spr,
                                  input int src, input logic [31:0] val);
        raster_t exp_line;
        cycle_num_t exp_cycle;
        bus_word_t word;
        bus_word_t older;
        bus_word_t oldest;
        exp_line = line % `RASTER_LINES;
        exp_cycle = cyc;
        wait_for_strobe(line * `CYCLES_PER_LINE + cyc);
        check_position(raster_line, raster_cycle, exp_line, exp_cycle);
        // latched outputs are one tick behind the strobe
        @(negedge clk_dot4x);
        word = val[11:0];
        if (src >= 0) begin
            word = bus_word_at(src * `CYCLES_PER_LINE + cyc);
        end
        case (kind)
            0: check_pixel(pixels_read, word[7:0]);
            1: check_char(char_read, word);
            2: check_ptr(sprite_ptr_o, spr, word[7:0]);
            3: begin
                if (src >= 0) begin
                    // oldest byte shifted furthest up
                    older = bus_word_at((src - 1) * `CYCLES_PER_LINE + cyc);
                    oldest = bus_word_at((src - 2) * `CYCLES_PER_LINE + cyc);
                    check_sprite(sprite_pixels_o, spr, {oldest[7:0], older[7:0], word[7:0]});
                end else begin
                    check_sprite(sprite_pixels_o, spr, val[23:0]);
                end
            end
            default: abort_run($sformatf("unknown checkpoint kind %0d in testdata", kind));
        endcase
    endtask

    initial begin : main_flow
        int fd;
        int ch;
        int nread;
        int a;
        int b;
        int line;
        int cyc;
        int kind;
        int spr;
        int src;
        logic [31:0] val;
        logic [7:0] rdata;
        bit started;
        bit done;
        clk_dot4x = 1'b0;
        rst = 1'b1;
        paddr = 4'd0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 8'd0;
        dbi = '0;
        seed = 32'd91;
        error_count = 0;
        check_count = 0;
        started = 1'b0;
        done = 1'b0;
        fd = $fopen("vic_fetch_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open vic_fetch_testdata.txt");
        end
        // one record per line, led by a command letter
        while (!done) begin
            ch = $fgetc(fd);
            if (ch == -1) begin
                done = 1'b1;
            end else if (ch == "#") begin
                while ((ch != "\n") && (ch != -1)) begin
                    ch = $fgetc(fd);
                end
            end else if (ch == "s") begin
                nread = $fscanf(fd, "%d", a);
                seed = a;
                reset_dut();
                started = 1'b1;
            end else if ((ch == "w") || (ch == "r") || (ch == "c")) begin
                if (!started) begin
                    abort_run("testdata has a record before the seed line");
                end
                if (ch == "c") begin
                    nread = $fscanf(fd, "%d %d %d %d %d %h", line, cyc, kind, spr, src, val);
                    if (nread != 6) begin
                        abort_run("malformed checkpoint record in testdata");
                    end
                    run_checkpoint(line, cyc, kind, spr, src, val);
                end else begin
                    nread = $fscanf(fd, "%h %h", a, b);
                    if (nread != 2) begin
                        abort_run("malformed register record in testdata");
                    end
                    if (ch == "w") begin
                        apb_transfer(1'b1, a[3:0], b[7:0], rdata);
                    end else begin
                        apb_transfer(1'b0, a[3:0], 8'h00, rdata);
                        check_reg(a[3:0], rdata, b[7:0]);
                    end
                end
            end else if ((ch != " ") && (ch != "\t") && (ch != "\n") && (ch != "\r")) begin
                abort_run("unexpected character in testdata");
            end
        end
        $fclose(fd);
        $display("%0d values checked", check_count);
        if (error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d checks failed", error_count));
        end
    end

endmodule

// File: vic_apb_regs.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_apb_regs
    import vic_pkg::*;
(
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  logic [3:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [7:0]                  pwdata,
    output logic [7:0]                  prdata,
    output logic                        pready,
    output logic                        den,
    output logic [2:0]                  yscroll,
    output sprite_mask_t                sprite_en,
    output logic [`NUM_SPRITES*8-1:0]   sprite_y
);

    // one y compare value per sprite
    logic [7:0] spr_y [`NUM_SPRITES];
    logic wr_en;
    logic y_hit;
    logic [3:0] y_sel;
    sprite_idx_t y_idx;

    // no wait states
    assign pready = 1'b1;

    // write lands on the access phase
    assign wr_en = psel && penable && pwrite;

    // sprite y block at 2..9
    assign y_hit = (paddr >= 4'd2) && (paddr < 4'd2 + `NUM_SPRITES);
    assign y_sel = paddr - 4'd2;
    assign y_idx = y_sel[2:0];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            den <= 1'b0;
            yscroll <= 3'd0;
            sprite_en <= '0;
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                spr_y[n] <= 8'd0;
            end
        end else if (wr_en) begin
            case (paddr)
                4'd0: begin
                    // control, den in bit 4, yscroll low 3
                    den <= pwdata[4];
                    yscroll <= pwdata[2:0];
                end
                4'd1: sprite_en <= pwdata;
                default: begin
                    if (y_hit) begin
                        spr_y[y_idx] <= pwdata;
                    end
                end
            endcase
        end
    end

    // read mux, unmapped reads as zero
    always_comb begin
        prdata = 8'd0;
        if (paddr == 4'd0) begin
            prdata = {3'b000, den, 1'b0, yscroll};
        end else if (paddr == 4'd1) begin
            prdata = sprite_en;
        end else if (y_hit) begin
            prdata = spr_y[y_idx];
        end
    end

    // pack y registers for the dma block
    always_comb begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            sprite_y[n*8 +: 8] = spr_y[n];
        end
    end

endmodule

// File: vic_defs.svh
`ifndef VIC_DEFS_SVH
`define VIC_DEFS_SVH

// hardware sprites
`define NUM_SPRITES 8

// bus cycle types, one per strobe
// sprite pointer fetch
`define VIC_LP 4'd0
// sprite data bytes 1..3
`define VIC_HS1 4'd1
`define VIC_LS2 4'd2
`define VIC_HS3 4'd3
// badline char slot, alone or paired with graphics
`define VIC_HRC 4'd4
`define VIC_HGC 4'd5
// non-badline char slot, alone or paired with graphics
`define VIC_HRX 4'd6
`define VIC_HGI 4'd7
// graphics fetch on its own
`define VIC_LG 4'd8
// dram refresh
`define VIC_LR 4'd9
// no fetch
`define VIC_IDL 4'd10

// line geometry
`define CHARS_PER_LINE 40
`define CYCLES_PER_LINE 63
// shortened frame, 312 for a full PAL frame
`define RASTER_LINES 48
// clk_dot4x ticks per bus cycle, 32 on the real chip
`define PHASE_TICKS 8
`define SPRITE_LINES 21

// display window
`define FIRST_DMA_LINE 8
`define LAST_DMA_LINE 39

// cycle slot layout
`define SPRITE_FIRST_CYCLE 52
`define REFRESH_FIRST_CYCLE 5
`define REFRESH_CYCLES 5
`define CHAR_FIRST_CYCLE 11

`endif

// File: vic_fetch_testdata.txt
# s seed | w addr data | r addr expected, register fields in hex
# c line cycle kind sprite src value: kind 0 pixel 1 char 2 pointer 3 sprite, src -1 uses value
s 91
r a 00
w 0 13
r 0 13
w 1 01
r 1 01
w 2 0c
w 9 2a
r 2 0c
r 9 2a
c 11 11 1 0 11 0
c 11 20 0 0 11 0
c 11 30 1 0 11 0
c 11 50 1 0 11 0
c 11 52 2 0 -1 ff
c 12 11 1 0 11 0
c 12 50 1 0 11 0
c 12 52 2 0 12 0
c 12 58 2 3 -1 ff
c 13 3 2 7 -1 ff
c 14 53 3 0 14 0
c 18 40 1 0 11 0
c 19 11 1 0 19 0
c 20 11 1 0 19 0
w 0 03
r 0 03
c 27 25 1 0 19 0
c 30 25 1 0 19 0
c 32 52 2 0 32 0
c 33 52 2 0 -1 ff
c 42 7 0 0 -1 0
c 42 20 1 0 -1 0
c 42 21 0 0 42 0
c 59 30 1 0 -1 0
c 59 31 0 0 59 0

// File: vic_fetch_top.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_fetch_top
    import vic_pkg::*;
(
    input  logic            clk_dot4x,
    input  logic            rst,
    input  logic [3:0]      paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [7:0]      pwdata,
    input  bus_word_t       dbi,
    output logic [7:0]      prdata,
    output logic            pready,
    output raster_t         raster_line,
    output cycle_num_t      raster_cycle,
    output logic            phi_phase_start_dav,
    output pixel_byte_t     pixels_read,
    output char_word_t      char_read,
    output sprite_ptr_bus_t sprite_ptr_o,
    output sprite_pix_bus_t sprite_pixels_o
);

    // register outputs
    logic den;
    logic [2:0] yscroll;
    sprite_mask_t sprite_en;
    logic [`NUM_SPRITES*8-1:0] sprite_y;

    // sequencer to fetch path
    cycle_type_t cycle_type;
    sprite_idx_t sprite_cnt;
    logic aec;
    logic idle;
    logic line_start;
    sprite_mask_t sprite_dma;

    vic_apb_regs vic_apb_regs_inst (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .den(den),
        .yscroll(yscroll),
        .sprite_en(sprite_en),
        .sprite_y(sprite_y)
    );

    vic_raster_seq vic_raster_seq_inst (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .den(den),
        .yscroll(yscroll),
        .phi_phase_start_dav(phi_phase_start_dav),
        .cycle_type(cycle_type),
        .sprite_cnt(sprite_cnt),
        .aec(aec),
        .idle(idle),
        .raster_line(raster_line),
        .raster_cycle(raster_cycle),
        .line_start(line_start)
    );

    vic_sprite_dma vic_sprite_dma_inst (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .line_start(line_start),
        .raster_line(raster_line),
        .sprite_en(sprite_en),
        .sprite_y(sprite_y),
        .sprite_dma(sprite_dma)
    );

    // char_next stays internal to the fetch block
    bus_access bus_access_inst (
        .rst(rst),
        .clk_dot4x(clk_dot4x),
        .phi_phase_start_dav(phi_phase_start_dav),
        .cycle_type(cycle_type),
        .dbi(dbi),
        .idle(idle),
        .sprite_cnt(sprite_cnt),
        .aec(aec),
        .sprite_dma(sprite_dma),
        .sprite_ptr_o(sprite_ptr_o),
        .pixels_read(pixels_read),
        .sprite_pixels_o(sprite_pixels_o),
        .char_read(char_read),
        .char_next()
    );

endmodule

// File: vic_pkg.sv
`include "vic_defs.svh"

package vic_pkg;

    // cycle type code driven by the sequencer
    typedef logic [3:0] cycle_type_t;
    // colour nibble in 11:8, data byte in 7:0
    typedef logic [11:0] bus_word_t;
    // colour plus char pointer
    typedef logic [11:0] char_word_t;
    typedef logic [7:0] pixel_byte_t;
    typedef logic [2:0] sprite_idx_t;
    // one bit per sprite
    typedef logic [`NUM_SPRITES-1:0] sprite_mask_t;
    // sprite 0 in the top byte
    typedef logic [`NUM_SPRITES*8-1:0] sprite_ptr_bus_t;
    // 24 bits per sprite, sprite 0 on top
    typedef logic [`NUM_SPRITES*24-1:0] sprite_pix_bus_t;
    typedef logic [8:0] raster_t;
    typedef logic [5:0] cycle_num_t;

    // sequencer start-up
    typedef enum logic {seq_reset, seq_run} seq_state_t;

endpackage

// File: vic_raster_seq.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_raster_seq
    import vic_pkg::*;
(
    input  logic        clk_dot4x,
    input  logic        rst,
    input  logic        den,
    input  logic [2:0]  yscroll,
    output logic        phi_phase_start_dav,
    output cycle_type_t cycle_type,
    output sprite_idx_t sprite_cnt,
    output logic        aec,
    output logic        idle,
    output raster_t     raster_line,
    output cycle_num_t  raster_cycle,
    output logic        line_start
);

    seq_state_t state;
    logic [$clog2(`PHASE_TICKS)-1:0] tick_cnt;
    // which of the three sprite data bytes this line's s slot carries
    logic [1:0] s_part;
    logic badline;
    logic char_slot;
    logic last_cycle;
    // cycle offset from the first sprite slot
    cycle_num_t spr_off;

    // one settling tick out of reset, then free-running
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            state <= seq_reset;
            tick_cnt <= '0;
        end else begin
            case (state)
                seq_reset: state <= seq_run;
                default: begin
                    if (phi_phase_start_dav) begin
                        tick_cnt <= '0;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // strobe on the last tick of each bus cycle
    assign phi_phase_start_dav = (state == seq_run) && (tick_cnt == `PHASE_TICKS - 1);
    assign last_cycle = (raster_cycle == `CYCLES_PER_LINE - 1);
    assign line_start = phi_phase_start_dav && (raster_cycle == 6'd0);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_cycle <= '0;
            raster_line <= '0;
            s_part <= 2'd0;
        end else if (phi_phase_start_dav) begin
            if (last_cycle) begin
                raster_cycle <= '0;
                s_part <= (s_part == 2'd2) ? 2'd0 : s_part + 2'd1;
                if (raster_line == `RASTER_LINES - 1) begin
                    raster_line <= '0;
                end else begin
                    raster_line <= raster_line + 9'd1;
                end
            end else begin
                raster_cycle <= raster_cycle + 6'd1;
            end
        end
    end

    // badline: den, scroll match, inside the display window
    assign badline = den && (raster_line[2:0] == yscroll) &&
                     (raster_line >= `FIRST_DMA_LINE) && (raster_line <= `LAST_DMA_LINE);
    assign char_slot = (raster_cycle >= `CHAR_FIRST_CYCLE) &&
                       (raster_cycle < `CHAR_FIRST_CYCLE + `CHARS_PER_LINE);

    // cpu loses the bus only on badline char slots
    assign aec = !(badline && char_slot);

    // idle drops on a badline, comes back after the window
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            idle <= 1'b1;
        end else if (phi_phase_start_dav) begin
            if (badline) begin
                idle <= 1'b0;
            end else if (last_cycle && (raster_line == `LAST_DMA_LINE)) begin
                idle <= 1'b1;
            end
        end
    end

    // sprite slots wrap across the line end
    always_comb begin
        if (raster_cycle >= `SPRITE_FIRST_CYCLE) begin
            spr_off = raster_cycle - cycle_num_t'(`SPRITE_FIRST_CYCLE);
        end else begin
            spr_off = raster_cycle + cycle_num_t'(`CYCLES_PER_LINE - `SPRITE_FIRST_CYCLE);
        end
    end

    // cycle table
    always_comb begin
        cycle_type = `VIC_IDL;
        sprite_cnt = '0;
        if (spr_off < 2 * `NUM_SPRITES) begin
            // two-cycle pair per sprite, pointer first
            sprite_cnt = sprite_idx_t'(spr_off >> 1);
            if (!spr_off[0]) begin
                cycle_type = `VIC_LP;
            end else begin
                case (s_part)
                    2'd0: cycle_type = `VIC_HS1;
                    2'd1: cycle_type = `VIC_LS2;
                    default: cycle_type = `VIC_HS3;
                endcase
            end
        end else if ((raster_cycle >= `REFRESH_FIRST_CYCLE) &&
                     (raster_cycle < `REFRESH_FIRST_CYCLE + `REFRESH_CYCLES)) begin
            cycle_type = `VIC_LR;
        end else if (char_slot) begin
            // char and graphics halves share one strobe here
            cycle_type = badline ? `VIC_HGC : `VIC_HGI;
        end
    end

endmodule

// File: vic_sprite_dma.sv
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_sprite_dma
    import vic_pkg::*;
(
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  logic                        line_start,
    input  raster_t                     raster_line,
    input  sprite_mask_t                sprite_en,
    input  logic [`NUM_SPRITES*8-1:0]   sprite_y,
    output sprite_mask_t                sprite_dma
);

    // lines left per sprite
    logic [$clog2(`SPRITE_LINES + 1)-1:0] line_cnt [`NUM_SPRITES];
    sprite_mask_t y_match;

    // compare against low 8 bits of the raster
    always_comb begin
        for (int n = 0; n < `NUM_SPRITES; n++) begin
            y_match[n] = sprite_en[n] && (sprite_y[n*8 +: 8] == raster_line[7:0]);
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            sprite_dma <= '0;
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                line_cnt[n] <= '0;
            end
        end else if (line_start) begin
            for (int n = 0; n < `NUM_SPRITES; n++) begin
                if (sprite_dma[n]) begin
                    // running, a new match is ignored
                    if (line_cnt[n] == 1) begin
                        sprite_dma[n] <= 1'b0;
                    end
                    line_cnt[n] <= line_cnt[n] - 1'b1;
                end else if (y_match[n]) begin
                    sprite_dma[n] <= 1'b1;
                    line_cnt[n] <= `SPRITE_LINES;
                end
            end
        end
    end

endmodule

// File: vlog.f
+incdir+.
vic_pkg.sv
vic_apb_regs.sv
vic_raster_seq.sv
vic_sprite_dma.sv
bus_access.sv
vic_fetch_top.sv
tb_vic_fetch.sv
